/* files.f */
rtl/vchess_pkg.sv
rtl/eval_if.sv
rtl/ctrl_regs.sv
rtl/board_loader.sv
rtl/material_eval.sv
rtl/xorshift32.sv
rtl/vchess_top.sv
tb/tb_vchess.sv

/* rtl/board_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module board_loader (
   input  logic               clk,
   input  logic               rst_n,
   input  vchess_pkg::board_t new_board,
   input  logic               new_board_go,
   input  logic               white_to_move,
   output vchess_pkg::board_t board,
   output logic               board_white_to_move,
   output logic               board_valid
);
   import vchess_pkg::*;

   logic go_q;
   logic go_rise;
   logic opening_pending;

   // Only a 0 to 1 change of go starts a load
   assign go_rise = new_board_go && !go_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         go_q                <= 1'b0;
         opening_pending     <= 1'b1;            // Evaluate the opening once
         board               <= OPENING_BOARD;
         board_white_to_move <= 1'b1;
         board_valid         <= 1'b0;
      end
      else
      begin
         go_q            <= new_board_go;
         opening_pending <= 1'b0;
         board_valid     <= go_rise || opening_pending;
         if (go_rise)
         begin
            board               <= new_board;
            board_white_to_move <= white_to_move;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  reg_wr,
   input  logic                  reg_rd,
   input  vchess_pkg::reg_addr_t reg_addr,
   input  vchess_pkg::rank_t     reg_wdata,
   output vchess_pkg::rank_t     reg_rdata,
   output logic                  reg_rvalid,
   input  logic                  calib_async,
   output vchess_pkg::board_t    new_board,
   output logic                  new_board_go,
   output logic                  white_to_move,
   output vchess_pkg::eval_t     score_mask,
   eval_if.sink                  result
);
   import vchess_pkg::*;

   rank_t     rank_q [RANKS];
   reg_addr_t rank_off;
   logic      rank_hit;
   logic      ctrl_wr;
   logic      done;
   eval_t     eval_q;
   material_t mat_white_q;
   material_t mat_black_q;
   logic      insufficient_q;
   logic      calib_meta;
   logic      calib_sync;
   rank_t     rdata_d;

   assign rank_off = reg_addr - REG_RANK0;
   assign rank_hit = rank_off <= (REG_RANK7 - REG_RANK0);
   assign ctrl_wr  = reg_wr && (reg_addr == REG_CTRL);

   always_comb
   begin
      for (int r = 0; r < RANKS; r++)
      begin
         new_board[r * RANK_WIDTH +: RANK_WIDTH] = rank_q[r];
      end
   end

   // Rank words, captured result and read data
   always_ff @(posedge clk)
   begin
      if (reg_wr && rank_hit)
         rank_q[rank_off[2:0]] <= reg_wdata;
      if (result.valid)
      begin
         eval_q         <= result.eval;          // Newest result wins
         mat_white_q    <= result.material_white;
         mat_black_q    <= result.material_black;
         insufficient_q <= result.insufficient;
      end
      if (reg_rd)
         reg_rdata <= rdata_d;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         new_board_go  <= 1'b0;
         white_to_move <= 1'b0;
         score_mask    <= '0;
         done          <= 1'b0;
         reg_rvalid    <= 1'b0;
         calib_meta    <= 1'b0;
         calib_sync    <= 1'b0;
      end
      else
      begin
         if (ctrl_wr)
         begin
            new_board_go  <= reg_wdata[CTRL_GO_BIT];
            white_to_move <= reg_wdata[CTRL_WTM_BIT];
         end
         if (reg_wr && (reg_addr == REG_SCORE_MASK))
            score_mask <= eval_t'(reg_wdata[EVAL_WIDTH-1:0]);
         if (ctrl_wr)
            done <= 1'b0;                        // Clear beats a same-cycle result
         else if (result.valid)
            done <= 1'b1;
         reg_rvalid <= reg_rd;
         calib_meta <= calib_async;              // Two-flop synchroniser
         calib_sync <= calib_meta;
      end
   end

   always_comb
   begin
      rdata_d = '0;
      case (reg_addr)
         REG_CTRL:
         begin
            rdata_d[CTRL_GO_BIT]  = new_board_go;
            rdata_d[CTRL_WTM_BIT] = white_to_move;
         end
         REG_SCORE_MASK:
            rdata_d = {{(RANK_WIDTH - EVAL_WIDTH){1'b0}}, score_mask};
         REG_STATUS:
         begin
            rdata_d[STATUS_DONE_BIT]  = done;
            rdata_d[STATUS_INSUF_BIT] = insufficient_q;
            rdata_d[STATUS_CALIB_BIT] = calib_sync;
         end
         REG_EVAL:
            rdata_d = {{(RANK_WIDTH - EVAL_WIDTH){eval_q[EVAL_WIDTH-1]}}, eval_q};
         REG_MAT_WHITE:
            rdata_d = {{(RANK_WIDTH - MATERIAL_WIDTH){1'b0}}, mat_white_q};
         REG_MAT_BLACK:
            rdata_d = {{(RANK_WIDTH - MATERIAL_WIDTH){1'b0}}, mat_black_q};
         default:
         begin
            if (rank_hit)
               rdata_d = rank_q[rank_off[2:0]];   // Otherwise unmapped, reads zero
         end
      endcase
   end

endmodule

`default_nettype wire

/* rtl/eval_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface eval_if;
   import vchess_pkg::*;

   eval_t     eval;
   material_t material_white;
   material_t material_black;
   logic      insufficient;
   logic      valid;           // One-cycle pulse, qualifies the rest

   modport source (output eval, output material_white, output material_black,
                   output insufficient, output valid);

   modport sink (input eval, input material_white, input material_black,
                 input insufficient, input valid);

endinterface

`default_nettype wire

/* rtl/material_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module material_eval (
   input  logic               clk,
   input  logic               rst_n,
   input  vchess_pkg::board_t board,
   input  logic               board_white_to_move,
   input  logic               board_valid,
   input  vchess_pkg::rand_t  rand_word,
   input  vchess_pkg::eval_t  score_mask,
   eval_if.source             result
);
   import vchess_pkg::*;

   material_t white_rank_d [RANKS];
   material_t black_rank_d [RANKS];
   logic      has_piece_d;

   material_t white_rank_s1 [RANKS];
   material_t black_rank_s1 [RANKS];
   logic      has_piece_s1;
   logic      wtm_s1;
   logic      valid_s1;

   material_t white_total_d;
   material_t black_total_d;
   eval_t     diff_d;

   material_t white_s2;
   material_t black_s2;
   eval_t     base_s2;
   logic      insufficient_s2;
   logic      valid_s2;

   // Kings, empty squares and code 7 are worth nothing
   function automatic material_t piece_value(input piece_t p);
      piece_t kind;
      kind = p;
      kind[PIECE_BLACK_BIT] = 1'b0;
      case (kind)
         WHITE_PAWN:   return PAWN_VALUE;
         WHITE_KNIGHT: return KNIGHT_VALUE;
         WHITE_BISHOP: return BISHOP_VALUE;
         WHITE_ROOK:   return ROOK_VALUE;
         WHITE_QUEEN:  return QUEEN_VALUE;
         default:      return '0;
      endcase
   endfunction

   always_comb
   begin
      piece_t p;
      has_piece_d = 1'b0;
      for (int r = 0; r < RANKS; r++)
      begin
         white_rank_d[r] = '0;
         black_rank_d[r] = '0;
         for (int f = 0; f < FILES; f++)
         begin
            p = board[r * RANK_WIDTH + f * PIECE_WIDTH +: PIECE_WIDTH];
            if (p[PIECE_BLACK_BIT])
               black_rank_d[r] += piece_value(p);
            else
               white_rank_d[r] += piece_value(p);
            if (piece_value(p) != '0)
               has_piece_d = 1'b1;                // Anything besides a king
         end
      end
   end

   always_comb
   begin
      white_total_d = '0;
      black_total_d = '0;
      for (int r = 0; r < RANKS; r++)
      begin
         white_total_d += white_rank_s1[r];
         black_total_d += black_rank_s1[r];
      end
   end

   assign diff_d = eval_t'(white_total_d) - eval_t'(black_total_d);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_s1     <= 1'b0;
         valid_s2     <= 1'b0;
         result.valid <= 1'b0;
      end
      else
      begin
         valid_s1     <= board_valid;
         valid_s2     <= valid_s1;
         result.valid <= valid_s2;
      end
   end

   always_ff @(posedge clk)
   begin
      white_rank_s1   <= white_rank_d;           // Stage 1, per-rank sums
      black_rank_s1   <= black_rank_d;
      has_piece_s1    <= has_piece_d;
      wtm_s1          <= board_white_to_move;
      white_s2        <= white_total_d;          // Stage 2, totals and sign
      black_s2        <= black_total_d;
      base_s2         <= wtm_s1 ? diff_d : -diff_d;
      insufficient_s2 <= !has_piece_s1;
      // Stage 3, masked noise on top of the base score
      result.eval           <= base_s2 + (eval_t'(rand_word[EVAL_WIDTH-1:0]) & score_mask);
      result.material_white <= white_s2;
      result.material_black <= black_s2;
      result.insufficient   <= insufficient_s2;
   end

endmodule

`default_nettype wire

/* rtl/vchess_pkg.sv */
`default_nettype none

package vchess_pkg;

   localparam int PIECE_WIDTH    = 4;
   localparam int FILES          = 8;
   localparam int RANKS          = 8;
   localparam int RANK_WIDTH     = FILES * PIECE_WIDTH;
   localparam int BOARD_WIDTH    = RANKS * RANK_WIDTH;
   localparam int EVAL_WIDTH     = 24;
   localparam int MATERIAL_WIDTH = 16;
   localparam int REG_ADDR_WIDTH = 4;
   localparam int RAND_WIDTH     = 32;

   typedef logic [PIECE_WIDTH-1:0]       piece_t;
   typedef logic [BOARD_WIDTH-1:0]       board_t;      // Square rank*8+file, rank 0 is white's
   typedef logic [RANK_WIDTH-1:0]        rank_t;       // Also the register data width
   typedef logic signed [EVAL_WIDTH-1:0] eval_t;
   typedef logic [MATERIAL_WIDTH-1:0]    material_t;
   typedef logic [REG_ADDR_WIDTH-1:0]    reg_addr_t;
   typedef logic [RAND_WIDTH-1:0]        rand_t;

   localparam material_t PAWN_VALUE   = 16'd100;
   localparam material_t KNIGHT_VALUE = 16'd320;
   localparam material_t BISHOP_VALUE = 16'd330;
   localparam material_t ROOK_VALUE   = 16'd500;
   localparam material_t QUEEN_VALUE  = 16'd900;

   localparam int PIECE_BLACK_BIT = 3;

   localparam piece_t EMPTY_POSN    = 4'h0;
   localparam piece_t WHITE_PAWN    = 4'h1;
   localparam piece_t WHITE_KNIGHT  = 4'h2;
   localparam piece_t WHITE_BISHOP  = 4'h3;
   localparam piece_t WHITE_ROOK    = 4'h4;
   localparam piece_t WHITE_QUEEN   = 4'h5;
   localparam piece_t WHITE_KING    = 4'h6;
   localparam piece_t BLACK_PAWN    = 4'h9;
   localparam piece_t BLACK_KNIGHT  = 4'hA;
   localparam piece_t BLACK_BISHOP  = 4'hB;
   localparam piece_t BLACK_ROOK    = 4'hC;
   localparam piece_t BLACK_QUEEN   = 4'hD;
   localparam piece_t BLACK_KING    = 4'hE;

   // Back ranks listed from file 7 down to file 0
   localparam rank_t OPENING_WHITE_BACK = {WHITE_ROOK, WHITE_KNIGHT, WHITE_BISHOP, WHITE_KING,
                                           WHITE_QUEEN, WHITE_BISHOP, WHITE_KNIGHT, WHITE_ROOK};
   localparam rank_t OPENING_BLACK_BACK = {BLACK_ROOK, BLACK_KNIGHT, BLACK_BISHOP, BLACK_KING,
                                           BLACK_QUEEN, BLACK_BISHOP, BLACK_KNIGHT, BLACK_ROOK};
   localparam board_t OPENING_BOARD = {OPENING_BLACK_BACK, {FILES{BLACK_PAWN}},
                                       {(4 * FILES){EMPTY_POSN}},
                                       {FILES{WHITE_PAWN}}, OPENING_WHITE_BACK};

   localparam reg_addr_t REG_RANK0      = 4'd0;
   localparam reg_addr_t REG_RANK7      = 4'd7;
   localparam reg_addr_t REG_CTRL       = 4'd8;
   localparam reg_addr_t REG_SCORE_MASK = 4'd9;
   localparam reg_addr_t REG_STATUS     = 4'd10;  // Read only
   localparam reg_addr_t REG_EVAL       = 4'd11;
   localparam reg_addr_t REG_MAT_WHITE  = 4'd12;
   localparam reg_addr_t REG_MAT_BLACK  = 4'd13;

   localparam int CTRL_GO_BIT           = 0;
   localparam int CTRL_WTM_BIT          = 1;
   localparam int STATUS_DONE_BIT       = 0;
   localparam int STATUS_INSUF_BIT      = 1;
   localparam int STATUS_CALIB_BIT      = 2;

   localparam rand_t XORSHIFT_SEED = 32'h2545_F491;  // Any nonzero value

endpackage

`default_nettype wire

/* rtl/vchess_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vchess_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  reg_wr,
   input  logic                  reg_rd,
   input  vchess_pkg::reg_addr_t reg_addr,
   input  vchess_pkg::rank_t     reg_wdata,
   output vchess_pkg::rank_t     reg_rdata,
   output logic                  reg_rvalid,
   input  logic                  calib_async
);
   import vchess_pkg::*;

   board_t new_board;
   logic   new_board_go;
   logic   white_to_move;
   eval_t  score_mask;
   board_t board;
   logic   board_white_to_move;
   logic   board_valid;
   rand_t  rand_word;

   eval_if eval_bus ();

   ctrl_regs ctrl_regs_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .reg_wr        (reg_wr),
      .reg_rd        (reg_rd),
      .reg_addr      (reg_addr),
      .reg_wdata     (reg_wdata),
      .reg_rdata     (reg_rdata),
      .reg_rvalid    (reg_rvalid),
      .calib_async   (calib_async),
      .new_board     (new_board),
      .new_board_go  (new_board_go),
      .white_to_move (white_to_move),
      .score_mask    (score_mask),
      .result        (eval_bus.sink)
   );

   board_loader board_loader_i (
      .clk                 (clk),
      .rst_n               (rst_n),
      .new_board           (new_board),
      .new_board_go        (new_board_go),
      .white_to_move       (white_to_move),
      .board               (board),
      .board_white_to_move (board_white_to_move),
      .board_valid         (board_valid)
   );

   material_eval material_eval_i (
      .clk                 (clk),
      .rst_n               (rst_n),
      .board               (board),
      .board_white_to_move (board_white_to_move),
      .board_valid         (board_valid),
      .rand_word           (rand_word),
      .score_mask          (score_mask),
      .result              (eval_bus.source)
   );

   xorshift32 xorshift32_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .rand_word (rand_word)   // Free-running noise source
   );

endmodule

`default_nettype wire

/* rtl/xorshift32.sv */
`timescale 1ns/1ps
`default_nettype none

module xorshift32 (
   input  logic              clk,
   input  logic              rst_n,
   output vchess_pkg::rand_t rand_word
);
   import vchess_pkg::*;

   rand_t step1;
   rand_t step2;
   rand_t step3;

   assign step1 = rand_word ^ (rand_word << 13);
   assign step2 = step1 ^ (step1 >> 17);
   assign step3 = step2 ^ (step2 << 5);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rand_word <= XORSHIFT_SEED;     // Zero would lock the generator
      else
         rand_word <= step3;
   end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module tb_vchess -f files.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
   exit 0
else
   exit 1
fi

/* tb/tb_vchess.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vchess;
   import vchess_pkg::*;

   localparam int MAX_CYCLES = 6000;    // 100 evaluations of up to 40 cycles plus margin
   localparam int DONE_POLLS = 40;

   logic        clk;
   logic        rst_n;
   logic        reg_wr;
   logic        reg_rd;
   reg_addr_t   reg_addr;
   rank_t       reg_wdata;
   rank_t       reg_rdata;
   logic        reg_rvalid;
   logic        calib_async;
   logic [31:0] lfsr = 32'd98;
   int          cycles = 0;
   int          noisy_results = 0;

   vchess_top dut_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic fail_run();
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         fail_run();
      end
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < n; i++)
      begin
         value = {value[30:0], lfsr[0]};
         lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return value;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("[ERROR] %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, expected,
                  actual);
         fail_run();
      end
   endtask

   task automatic write_reg(input reg_addr_t addr, input rank_t data);
      @(negedge clk);
      reg_wr    = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(negedge clk);
      reg_wr = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, output rank_t data);
      @(negedge clk);
      reg_rd   = 1'b1;
      reg_addr = addr;
      @(negedge clk);
      reg_rd = 1'b0;
      check_value("reg_rvalid", 32'd1, {31'd0, reg_rvalid});
      data = reg_rdata;
   endtask

   task automatic wait_done();
      rank_t status;
      int    polls;
      status = '0;
      polls  = 0;
      while (!status[STATUS_DONE_BIT])
      begin
         if (polls == DONE_POLLS)
         begin
            $display("No result arrived: done stayed low for %0d status reads", DONE_POLLS);
            fail_run();
         end
         read_reg(REG_STATUS, status);
         polls++;
      end
   endtask

   task automatic load_board(input board_t b, input logic wtm);
      for (int r = 0; r < RANKS; r++)
         write_reg(REG_RANK0 + reg_addr_t'(r), b[r * RANK_WIDTH +: RANK_WIDTH]);
      write_reg(REG_CTRL, {30'd0, wtm, 1'b0});   // go low first so the next write is an edge
      write_reg(REG_CTRL, {30'd0, wtm, 1'b1});
      wait_done();
   endtask

   function automatic int piece_worth(input piece_t p);
      case (p[2:0])
         3'd1:    return 100;
         3'd2:    return 320;
         3'd3:    return 330;
         3'd4:    return 500;
         3'd5:    return 900;
         default: return 0;                      // Empty, king, unused code
      endcase
   endfunction

   function automatic board_t random_board();
      board_t b;
      for (int s = 0; s < 64; s++)
         b[s * 4 +: 4] = (rand_bits(1) != 0) ? piece_t'(rand_bits(4)) : EMPTY_POSN;
      return b;
   endfunction

   // Reads back the result and compares it with the model
   task automatic check_result(input board_t b, input logic wtm, input logic [23:0] mask);
      int          white;
      int          black;
      int          base;
      rank_t       data;
      logic [23:0] noise;
      white = 0;
      black = 0;
      for (int s = 0; s < 64; s++)
      begin
         if (b[s * 4 + 3])
            black += piece_worth(b[s * 4 +: 4]);
         else
            white += piece_worth(b[s * 4 +: 4]);
      end
      base = wtm ? white - black : black - white;
      read_reg(REG_MAT_WHITE, data);
      check_value("material_white", white, data);
      read_reg(REG_MAT_BLACK, data);
      check_value("material_black", black, data);
      read_reg(REG_STATUS, data);
      check_value("insufficient", {31'd0, (white + black) == 0},
                  {31'd0, data[STATUS_INSUF_BIT]});
      read_reg(REG_EVAL, data);
      if (mask == '0)
         check_value("eval", base, data);
      else
      begin
         noise = data[23:0] - base[23:0];      // Modulo the 24-bit eval width
         check_value("eval noise outside mask", 32'd0, {8'd0, noise & ~mask});
         if (noise != '0)
            noisy_results++;
      end
   endtask

   initial
   begin
      board_t      b;
      logic        wtm;
      rank_t       data;
      rank_t       ranks [RANKS];
      logic [23:0] mask;
      int          sq;
      rst_n       = 1'b0;
      reg_wr      = 1'b0;
      reg_rd      = 1'b0;
      reg_addr    = '0;
      reg_wdata   = '0;
      calib_async = 1'b0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      wait_done();                               // Opening position needs no host write
      read_reg(REG_EVAL, data);
      check_value("opening eval", 32'd0, data);
      read_reg(REG_MAT_WHITE, data);
      check_value("opening material_white", 32'd4000, data);
      read_reg(REG_MAT_BLACK, data);
      check_value("opening material_black", 32'd4000, data);
      read_reg(REG_STATUS, data);
      check_value("opening insufficient", 32'd0, {31'd0, data[STATUS_INSUF_BIT]});

      repeat (60)
      begin
         b   = random_board();
         wtm = rand_bits(1) != 0;
         load_board(b, wtm);
         check_result(b, wtm, 24'd0);
      end

      repeat (6)
      begin
         for (int s = 0; s < 64; s++)
            b[s * 4 +: 4] = (rand_bits(2) != 0) ? EMPTY_POSN :
                            ((rand_bits(1) != 0) ? BLACK_KING : WHITE_KING);
         wtm = rand_bits(1) != 0;
         load_board(b, wtm);
         check_result(b, wtm, 24'd0);             // Kings only
         sq = int'(rand_bits(6));
         b[sq * 4 +: 4] = {1'(rand_bits(1)), 3'(rand_bits(3) % 5 + 1)};
         load_board(b, wtm);
         check_result(b, wtm, 24'd0);
      end

      repeat (8)
      begin
         mask = 24'(rand_bits(24));
         if (mask == '0)
            mask = 24'd1;
         write_reg(REG_SCORE_MASK, {8'd0, mask});
         b   = random_board();
         wtm = rand_bits(1) != 0;
         load_board(b, wtm);
         check_result(b, wtm, mask);
      end
      check_value("masked noise seen", 32'd1, {31'd0, noisy_results != 0});
      write_reg(REG_SCORE_MASK, 32'd0);

      for (int r = 0; r < RANKS; r++)
      begin
         ranks[r] = rand_bits(32);
         write_reg(REG_RANK0 + reg_addr_t'(r), ranks[r]);
      end
      for (int r = 0; r < RANKS; r++)
      begin
         read_reg(REG_RANK0 + reg_addr_t'(r), data);
         check_value("rank readback", ranks[r], data);
      end
      mask = 24'(rand_bits(24));
      write_reg(REG_SCORE_MASK, {8'd0, mask});
      read_reg(REG_SCORE_MASK, data);
      check_value("score_mask readback", {8'd0, mask}, data);
      write_reg(REG_SCORE_MASK, 32'd0);
      read_reg(REG_CTRL, data);
      check_value("ctrl readback", {30'd0, wtm, 1'b1}, data);
      for (int a = 14; a < 16; a++)
      begin
         read_reg(reg_addr_t'(a), data);
         check_value("unmapped read", 32'd0, data);
      end
      repeat (2)
      begin
         @(negedge clk);
         calib_async = ~calib_async;
         repeat (4) @(negedge clk);
         read_reg(REG_STATUS, data);
         check_value("calib", {31'd0, calib_async}, {31'd0, data[STATUS_CALIB_BIT]});
      end

      // go is still 1 here so this write only clears done
      write_reg(REG_CTRL, {30'd0, wtm, 1'b1});
      repeat (20)
      begin
         read_reg(REG_STATUS, data);
         check_value("done after clear", 32'd0, {31'd0, data[STATUS_DONE_BIT]});
      end
      b   = random_board();
      wtm = rand_bits(1) != 0;
      load_board(b, wtm);
      check_result(b, wtm, 24'd0);

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
